/* build.f */
rtl/fetchPkg.sv
rtl/pcGen.sv
rtl/fetchBus.sv
rtl/spillMerge.sv
rtl/instrOut.sv
rtl/fetchTop.sv
test/instrMemModel.sv
test/fetch_assertions.sv
test/fetchTb.sv

/* rtl/fetchBus.sv */
/* Wishbone classic read master, one aligned word per request.
   Requests are taken only while idle and a cycle is never aborted. */

module fetchBus (
  input  logic           clk,
  input  logic           rst,
  input  logic           fetchReq,
  input  fetchPkg::addrT fetchAddr,
  output logic           fetchDone,
  output fetchPkg::wordT fetchData,
  output logic           wbCyc,
  output logic           wbStb,
  output logic           wbWe,
  output fetchPkg::addrT wbAdr,
  input  fetchPkg::wordT wbDatI,
  input  logic           wbAck
);

  // Bus idle or waiting for the slave
  typedef enum logic {
    BusIdle = 1'b0,
    BusWait = 1'b1
  } busStateT;

  busStateT busState;

  // Slave answered the current cycle
  logic ackTaken;

  ////////////////////
  // Bus control

  always_ff @(posedge clk) begin
    if (rst) begin
      busState  <= BusIdle;
      fetchDone <= 1'b0;
    end else begin
      fetchDone <= 1'b0;
      case (busState)
        BusIdle: begin
          if (fetchReq) begin
            busState <= BusWait;
          end
        end
        BusWait: begin
          // cyc and stb drop in the cycle after the ack
          if (wbAck) begin
            busState  <= BusIdle;
            fetchDone <= 1'b1;
          end
        end
        default: busState <= BusIdle;
      endcase
    end
  end

  assign ackTaken = (busState == BusWait) && wbAck;

  ////////////////////
  // Address and read data

  always_ff @(posedge clk) begin
    // Word aligned address held for the whole cycle
    if ((busState == BusIdle) && fetchReq) begin
      wbAdr <= {fetchAddr[31:2], 2'b00};
    end
    // Read data registered with the done pulse
    if (ackTaken) begin
      fetchData <= wbDatI;
    end
  end

  // cyc and stb rise and fall together
  assign wbCyc = (busState == BusWait);
  assign wbStb = (busState == BusWait);

  // Instruction fetch never writes
  assign wbWe = 1'b0;

endmodule

/* rtl/fetchPkg.sv */
/* Shared types and constants for the RV32C fetch front end.
   All widths follow the 32-bit RV32 word. */

package fetchPkg;

  ////////////////////
  // Widths that carry a meaning

  // Byte address of a fetch or an instruction
  typedef logic [31:0] addrT;

  // One memory word or one full instruction
  typedef logic [31:0] wordT;

  // One 16-bit instruction parcel
  typedef logic [15:0] halfT;

  ////////////////////
  // Constants

  // First address fetched after reset
  localparam addrT ResetPc = 32'h0000_0000;

  // PC steps for full and compressed instructions
  localparam addrT StepFull = 32'd4;
  localparam addrT StepCompressed = 32'd2;

  // Low two opcode bits that mark a 32-bit instruction
  localparam logic [1:0] FullOp = 2'b11;

  ////////////////////
  // Spill state machine

  // Idle waits for room, First and Second are the two word fetches,
  // Hold drops the data of a fetch made stale by a redirect
  typedef enum logic [1:0] {
    Idle   = 2'd0,
    First  = 2'd1,
    Second = 2'd2,
    Hold   = 2'd3
  } spillStateT;

endpackage

/* rtl/fetchTop.sv */
/* RV32C instruction fetch front end with a Wishbone classic master.
   No caches and no branch prediction; redirects wait for the bus. */

module fetchTop (
  input  logic           clk,
  input  logic           rst,
  input  logic           redirect,
  input  fetchPkg::addrT redirectPc,
  output logic           wbCyc,
  output logic           wbStb,
  output logic           wbWe,
  output fetchPkg::addrT wbAdr,
  input  fetchPkg::wordT wbDatI,
  input  logic           wbAck,
  output logic           instrValid,
  output fetchPkg::wordT instr,
  output fetchPkg::addrT instrPc,
  output logic           compressed,
  input  logic           ready
);

  // PC of the head instruction
  fetchPkg::addrT pc;
  logic           advance;

  // spillMerge to fetchBus
  logic           fetchReq;
  fetchPkg::addrT fetchAddr;
  logic           fetchDone;
  fetchPkg::wordT fetchData;

  // spillMerge to instrOut
  logic           outFree;
  logic           mergeValid;
  fetchPkg::wordT mergeInstr;
  fetchPkg::addrT mergePc;

  ////////////////////
  // Blocks

  pcGen u_pcGen (
    .clk        (clk),
    .rst        (rst),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .advance    (advance),
    .compressed (compressed),
    .pc         (pc)
  );

  fetchBus u_fetchBus (
    .clk       (clk),
    .rst       (rst),
    .fetchReq  (fetchReq),
    .fetchAddr (fetchAddr),
    .fetchDone (fetchDone),
    .fetchData (fetchData),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatI    (wbDatI),
    .wbAck     (wbAck)
  );

  // Redirect doubles as the flush of the fetch path
  spillMerge u_spillMerge (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .flush      (redirect),
    .outFree    (outFree),
    .fetchReq   (fetchReq),
    .fetchAddr  (fetchAddr),
    .fetchDone  (fetchDone),
    .fetchData  (fetchData),
    .mergeValid (mergeValid),
    .mergeInstr (mergeInstr),
    .mergePc    (mergePc)
  );

  instrOut u_instrOut (
    .clk        (clk),
    .rst        (rst),
    .flush      (redirect),
    .mergeValid (mergeValid),
    .mergeInstr (mergeInstr),
    .mergePc    (mergePc),
    .outFree    (outFree),
    .advance    (advance),
    .instrValid (instrValid),
    .instr      (instr),
    .instrPc    (instrPc),
    .compressed (compressed),
    .ready      (ready)
  );

endmodule

/* rtl/instrOut.sv */
/* One-entry output register toward the decoder.
   Data stays stable while ready is low and a redirect empties it. */

module instrOut (
  input  logic           clk,
  input  logic           rst,
  input  logic           flush,
  input  logic           mergeValid,
  input  fetchPkg::wordT mergeInstr,
  input  fetchPkg::addrT mergePc,
  output logic           outFree,
  output logic           advance,
  output logic           instrValid,
  output fetchPkg::wordT instr,
  output fetchPkg::addrT instrPc,
  output logic           compressed,
  input  logic           ready
);

  // Incoming instruction is a single parcel
  logic isCompressed;

  assign isCompressed = (mergeInstr[1:0] != fetchPkg::FullOp);

  ////////////////////
  // Valid flag

  always_ff @(posedge clk) begin
    if (rst) begin
      instrValid <= 1'b0;
    end else if (flush) begin
      instrValid <= 1'b0;
    end else if (mergeValid) begin
      instrValid <= 1'b1;
    end else if (ready) begin
      // Transfer done or nothing held
      instrValid <= 1'b0;
    end
  end

  // Payload loaded only on a new instruction
  always_ff @(posedge clk) begin
    if (mergeValid) begin
      // Upper half of a compressed instruction reads as zero
      instr      <= isCompressed ? {16'h0000, mergeInstr[15:0]} : mergeInstr;
      instrPc    <= mergePc;
      compressed <= isCompressed;
    end
  end

  ////////////////////
  // Handshake

  // Room when empty or emptied this cycle
  assign outFree = !instrValid || ready;

  // pcGen steps on every accepted instruction
  assign advance = instrValid && ready;

endmodule

/* rtl/pcGen.sv */
/* Program counter of the instruction at the head of the fetch stream.
   Redirect targets must be halfword aligned since bit 0 is dropped. */

module pcGen (
  input  logic           clk,
  input  logic           rst,
  input  logic           redirect,
  input  fetchPkg::addrT redirectPc,
  input  logic           advance,
  input  logic           compressed,
  output fetchPkg::addrT pc
);

  // Size of the instruction that is leaving
  fetchPkg::addrT step;

  // Address the stream continues from
  fetchPkg::addrT target;

  ////////////////////
  // Next PC terms

  // Compressed instructions take one parcel
  assign step = compressed ? fetchPkg::StepCompressed : fetchPkg::StepFull;

  // Redirects land on a halfword
  assign target = {redirectPc[31:1], 1'b0};

  ////////////////////
  // PC register

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= fetchPkg::ResetPc;
    end else if (redirect) begin
      // A redirect wins over an accepted instruction
      pc <= target;
    end else if (advance) begin
      // Step past the instruction the decoder just took
      pc <= pc + step;
    end
  end

  // pc only ever moves while the output register holds data
  // or the core redirects, so spillMerge sees a stable value
  // for the whole of a one or two word fetch

endmodule

/* rtl/spillMerge.sv */
/* Fetches one or two words per instruction and merges a 32-bit
   instruction that spills over a word boundary into one word. */

module spillMerge (
  input  logic           clk,
  input  logic           rst,
  input  fetchPkg::addrT pc,
  input  logic           flush,
  input  logic           outFree,
  output logic           fetchReq,
  output fetchPkg::addrT fetchAddr,
  input  logic           fetchDone,
  input  fetchPkg::wordT fetchData,
  output logic           mergeValid,
  output fetchPkg::wordT mergeInstr,
  output fetchPkg::addrT mergePc
);

  fetchPkg::spillStateT state;
  fetchPkg::spillStateT stateNext;

  // Upper parcel of the first word
  fetchPkg::halfT upperHalf;

  // Parcel saved across the two fetches
  fetchPkg::halfT savedHalf;

  // Address of the following word before alignment
  fetchPkg::addrT nextWordPc;

  logic needSpill;
  logic startFirst;
  logic startSecond;

  ////////////////////
  // Spill detection

  assign upperHalf = fetchData[31:16];

  // Only a 32-bit instruction starting in the upper half spills
  assign needSpill = pc[1] && (upperHalf[1:0] == fetchPkg::FullOp);

  // Start a fetch only once the output register has room
  assign startFirst = (state == fetchPkg::Idle) && outFree && !flush;

  // Second word of a spilled instruction
  assign startSecond = (state == fetchPkg::First) && fetchDone && needSpill && !flush;

  ////////////////////
  // State machine

  always_comb begin
    stateNext = state;
    case (state)
      fetchPkg::Idle: begin
        if (startFirst) begin
          stateNext = fetchPkg::First;
        end
      end
      fetchPkg::First: begin
        if (flush) begin
          // Done already here means nothing is left to drop
          stateNext = fetchDone ? fetchPkg::Idle : fetchPkg::Hold;
        end else if (fetchDone) begin
          stateNext = needSpill ? fetchPkg::Second : fetchPkg::Idle;
        end
      end
      fetchPkg::Second: begin
        if (flush) begin
          stateNext = fetchDone ? fetchPkg::Idle : fetchPkg::Hold;
        end else if (fetchDone) begin
          stateNext = fetchPkg::Idle;
        end
      end
      fetchPkg::Hold: begin
        // Swallow the stale word
        if (fetchDone) begin
          stateNext = fetchPkg::Idle;
        end
      end
      default: stateNext = fetchPkg::Idle;
    endcase
  end

  // Requests go out one cycle after the decision,
  // so pc has already taken any advance by then
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= fetchPkg::Idle;
      fetchReq <= 1'b0;
    end else begin
      state    <= stateNext;
      fetchReq <= startFirst || startSecond;
    end
  end

  ////////////////////
  // Addresses and merge

  assign nextWordPc = pc + fetchPkg::StepFull;

  // Second fetch reads the word after the one holding pc
  assign fetchAddr = (state == fetchPkg::Second) ? {nextWordPc[31:2], 2'b00}
                                                 : {pc[31:2], 2'b00};

  // Keep the low part of the spilled instruction
  always_ff @(posedge clk) begin
    if (startSecond) begin
      savedHalf <= upperHalf;
    end
  end

  always_comb begin
    if (state == fetchPkg::Second) begin
      // Next word's low parcel goes on top
      mergeInstr = {fetchData[15:0], savedHalf};
    end else if (pc[1]) begin
      // Compressed instruction in the upper half
      mergeInstr = {16'h0000, upperHalf};
    end else begin
      mergeInstr = fetchData;
    end
  end

  // One pulse per finished instruction, none for flushed ones
  assign mergeValid = fetchDone && !flush &&
                      (((state == fetchPkg::First) && !needSpill) ||
                       (state == fetchPkg::Second));

  assign mergePc = pc;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module fetchTb -o simFetch

./obj_dir/simFetch > sim.log 2>&1 || true
cat sim.log

grep -q "^sim passed$" sim.log

/* test/fetchCases.txt */
# M wordIndex data : memory word at byte address wordIndex*4 (hex)
# R target count   : redirect to target (hex), then check count (hex) instructions
M 0 00500093
M 1 05134505
M 2 808200a0
M 3 00b00593
M 4 45854605
M 5 06930001
M 6 071300c0
M 7 470500d0
M 8 00e00793
M 9 00100073
M a 46014681
M b 08130001
M c 000000f0
R 0 10
R 10 6
R 6 5
R 16 4
R a 3
R 1e 5
R 0 18
R 2a 6

/* test/fetchTb.sv */
/* Testbench for fetchTop; reads test/fetchCases.txt from the project root.
   Expected stream comes from a walk over the testbench's own memory image. */

module fetchTb;

  localparam int TimeoutCycles = 300;

  logic           clk;
  logic           rst;
  logic           redirect;
  fetchPkg::addrT redirectPc;
  logic           wbCyc;
  logic           wbStb;
  logic           wbWe;
  fetchPkg::addrT wbAdr;
  fetchPkg::wordT wbDatI;
  logic           wbAck;
  logic           instrValid;
  fetchPkg::wordT instr;
  fetchPkg::addrT instrPc;
  logic           compressed;
  logic           ready;
  logic           stall;

  // Reference image and walk state
  fetchPkg::wordT image [0:255];
  fetchPkg::addrT expPc;
  logic [31:0]    lfsr;

  // Commands taken from the cases file
  fetchPkg::addrT cmdAddr [$];
  int             cmdCount [$];

  fetchTop u_dut (
    .clk        (clk),
    .rst        (rst),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbWe       (wbWe),
    .wbAdr      (wbAdr),
    .wbDatI     (wbDatI),
    .wbAck      (wbAck),
    .instrValid (instrValid),
    .instr      (instr),
    .instrPc    (instrPc),
    .compressed (compressed),
    .ready      (ready)
  );

  instrMemModel memModel (
    .clk    (clk),
    .rst    (rst),
    .stall  (stall),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatO (wbDatI),
    .wbAck  (wbAck)
  );

  bind fetchTop fetchAssertions u_fetchAssertions (
    .clk        (clk),
    .rst        (rst),
    .redirect   (redirect),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbAdr      (wbAdr),
    .wbAck      (wbAck),
    .instrValid (instrValid),
    .instr      (instr),
    .ready      (ready)
  );

  always #20 clk = ~clk;

  ////////////////////
  // Helpers

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic takeBit();
    logic b;
    b = lfsr[31];
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return b;
  endfunction

  task automatic stopRun(input string why);
    $display("%s at time %0t", why, $time);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  function automatic fetchPkg::halfT halfAt(input fetchPkg::addrT a);
    fetchPkg::wordT w;
    w = image[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // Low two bits both one start a 32-bit instruction
  function automatic logic isFull(input fetchPkg::addrT a);
    fetchPkg::halfT h;
    h = halfAt(a);
    return h[1:0] == 2'b11;
  endfunction

  function automatic fetchPkg::wordT expInstr(input fetchPkg::addrT a);
    if (isFull(a)) begin
      return {halfAt(a + 32'd2), halfAt(a)};
    end
    return {16'h0000, halfAt(a)};
  endfunction

  ////////////////////
  // Stimulus

  task automatic doRedirect(input fetchPkg::addrT target);
    @(posedge clk);
    #2;
    stall = takeBit();
    ready = 1'b0;
    redirect = 1'b1;
    redirectPc = target;
    expPc = {target[31:1], 1'b0};
    @(posedge clk);
    #2;
    redirect = 1'b0;
  endtask

  // Random ready, mostly high, and random wait states
  task automatic collect(input int count);
    int got;
    int idle;
    logic b0;
    logic b1;
    got = 0;
    idle = 0;
    while (got < count) begin
      @(posedge clk);
      #2;
      b0 = takeBit();
      b1 = takeBit();
      ready = b0 | b1;
      stall = takeBit();
      @(negedge clk);
      // Instruction fetch never writes
      checkEq("wbWe", {31'd0, wbWe}, 32'd0);
      if (instrValid && ready) begin
        checkEq("instrPc", instrPc, expPc);
        checkEq("instr", instr, expInstr(expPc));
        checkEq("compressed", {31'd0, compressed}, {31'd0, !isFull(expPc)});
        expPc = expPc + (isFull(expPc) ? 32'd4 : 32'd2);
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TimeoutCycles) begin
          stopRun("timeout waiting for an instruction from the DUT");
        end
      end
    end
  endtask

  task automatic readCases();
    int fd;
    int n;
    string line;
    logic [7:0] tag;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("test/fetchCases.txt", "r");
    if (fd == 0) begin
      stopRun("could not open the cases file");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%c %h %h", tag, a, b);
        if (n == 3 && tag == "M") begin
          image[a[7:0]] = b;
          memModel.mem[a[7:0]] = b;
        end else if (n == 3 && tag == "R") begin
          cmdAddr.push_back(a);
          cmdCount.push_back(int'(b));
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    fetchPkg::addrT fill;
    clk = 1'b0;
    rst = 1'b1;
    redirect = 1'b0;
    redirectPc = '0;
    ready = 1'b0;
    stall = 1'b0;
    lfsr = 32'hc9359917;
    expPc = fetchPkg::ResetPc;
    // Fill depends on every address bit
    for (int i = 0; i < 256; i++) begin
      fill = 32'(i) << 2;
      image[i] = (fill * 32'h9e3779b1) ^ 32'h5bd1e995;
      memModel.mem[i] = image[i];
    end
    readCases();
    if (cmdAddr.size() == 0) begin
      stopRun("cases file holds no redirect commands");
    end
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    foreach (cmdAddr[k]) begin
      doRedirect(cmdAddr[k]);
      collect(cmdCount[k]);
    end
    @(posedge clk);
    #2;
    ready = 1'b0;
    repeat (4) @(posedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

/* test/fetch_assertions.sv */
/* Protocol checks on the Wishbone master and the decoder handshake.
   Bound into fetchTop; checks are off during reset. */

module fetchAssertions (
  input logic           clk,
  input logic           rst,
  input logic           redirect,
  input logic           wbCyc,
  input logic           wbStb,
  input fetchPkg::addrT wbAdr,
  input logic           wbAck,
  input logic           instrValid,
  input fetchPkg::wordT instr,
  input logic           ready
);

  ////////////////////
  // Wishbone

  // Strobe only inside a cycle
  stbInCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
    else $error("wbStb high without wbCyc");

  // Address held until the slave answers
  adrStable: assert property (@(posedge clk) disable iff (rst)
    (wbStb && !wbAck) |=> $stable(wbAdr))
    else $error("wbAdr changed before wbAck");

  ////////////////////
  // Decoder side

  // A stalled instruction stays put unless a redirect clears it
  outHold: assert property (@(posedge clk) disable iff (rst)
    (instrValid && !ready && !redirect) |=> (instrValid && $stable(instr)))
    else $error("instruction changed while stalled");

endmodule

/* test/instrMemModel.sv */
/* Wishbone classic slave memory, 256 words, read only.
   Wait states come from the stall input and the testbench writes mem directly. */

module instrMemModel (
  input  logic           clk,
  input  logic           rst,
  input  logic           stall,
  input  logic           wbCyc,
  input  logic           wbStb,
  input  logic           wbWe,
  input  fetchPkg::addrT wbAdr,
  output fetchPkg::wordT wbDatO,
  output logic           wbAck
);

  // Word storage, indexed by address bits 9:2
  fetchPkg::wordT mem [0:255];

  // New request that has not been answered yet
  logic pending;

  assign pending = wbCyc && wbStb && !wbWe && !wbAck;

  ////////////////////
  // Ack and read data

  always_ff @(posedge clk) begin
    if (rst) begin
      wbAck <= 1'b0;
    end else begin
      // One ack per cycle, held back while stalled
      wbAck <= pending && !stall;
    end
  end

  always_ff @(posedge clk) begin
    // Data registered alongside the ack
    wbDatO <= mem[wbAdr[9:2]];
  end

endmodule
